// File: include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define XLEN 32

// RV32 with I, M, S and U
`define MISA_VALUE 32'h4014_1100

// machine information, read only
`define CSR_MISA      12'h301
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

// machine trap setup and handling
`define CSR_MSTATUS   12'h300
`define CSR_MEDELEG   12'h302
`define CSR_MIDELEG   12'h303
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// supervisor views and registers
`define CSR_SSTATUS   12'h100
`define CSR_SIE       12'h104
`define CSR_STVEC     12'h105
`define CSR_SSCRATCH  12'h140
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143
`define CSR_SIP       12'h144

`define CSR_MCYCLE    12'hB00
`define CSR_MTIMECMP  12'h7C0 // custom, machine timer compare
`define CSR_STIMECMP  12'h5C0 // custom, supervisor timer compare

`endif

// File: src/priv_pkg.sv
`include "csr_defines.svh"

package priv_pkg;

	typedef enum logic [1:0]
	{
		U = 2'd0,
		S = 2'd1,
		M = 2'd3
	} mode_t;

	typedef logic [4:0] cause_code_t;

	// pc is also the resume pc for an interrupt while valid is low
	typedef struct packed
	{
		logic valid;
		cause_code_t code;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] tval;
	} trap_req_t;

	typedef struct packed
	{
		logic mret;
		logic sret;
	} ret_req_t;

	typedef struct packed
	{
		logic valid;
		logic [`XLEN-1:0] pc;
	} redirect_t;

	typedef struct packed
	{
		logic take;
		logic to_s;    // target mode is S, else M
		logic is_irq;
		cause_code_t code;
		logic [`XLEN-1:0] epc;
		logic [`XLEN-1:0] tval;
		logic do_mret;
		logic do_sret;
	} trap_cmd_t;

endpackage

// File: src/csr_pkg.sv
`include "csr_defines.svh"

package csr_pkg;

	typedef logic [11:0] csr_addr_t;
	typedef logic [`XLEN-1:0] csr_data_t;

	// write-back side port
	typedef struct packed
	{
		logic we;
		csr_addr_t addr;
		csr_data_t wdata;
	} csr_access_t;

	typedef struct packed
	{
		logic mie;
		logic sie;
		logic mpie;
		logic spie;
		priv_pkg::mode_t mpp;
		logic spp;
		logic sum;
		priv_pkg::mode_t mode; // current privilege
	} status_t;

	typedef struct packed
	{
		csr_data_t cycle;
		csr_data_t mtimecmp;
		csr_data_t stimecmp;
	} timer_view_t;

endpackage

// File: src/trap_ctrl.sv
module trap_ctrl
(
	input logic clk,
	input logic nrst,
	input priv_pkg::trap_req_t trap_req,
	input priv_pkg::ret_req_t ret_req,
	input logic stall,
	input logic irq_valid,
	input priv_pkg::cause_code_t irq_code,
	input csr_pkg::status_t status,
	input logic [15:0] medeleg,
	input logic [15:0] mideleg,
	input csr_pkg::csr_data_t mtvec,
	input csr_pkg::csr_data_t stvec,
	input csr_pkg::csr_data_t mepc,
	input csr_pkg::csr_data_t sepc,
	output priv_pkg::trap_cmd_t trap_cmd,
	output priv_pkg::redirect_t redirect,
	output logic irq_taken
);
	logic from_lower;
	logic exc_to_s;
	logic irq_to_s;
	logic irq_entry;

	// traps taken in M never leave M
	assign from_lower = (status.mode != priv_pkg::M);
	assign exc_to_s = from_lower && !trap_req.code[4] && medeleg[trap_req.code[3:0]];
	assign irq_to_s = from_lower && !irq_code[4] && mideleg[irq_code[3:0]];

	// interrupts wait for exceptions, returns and stall
	assign irq_entry = irq_valid && !stall && !trap_req.valid
		&& !ret_req.mret && !ret_req.sret;

	always_comb
	begin
		trap_cmd = '0;
		redirect = '0;
		if (trap_req.valid)
		begin
			trap_cmd.take = 1'b1;
			trap_cmd.to_s = exc_to_s;
			trap_cmd.code = trap_req.code;
			trap_cmd.epc = trap_req.pc;
			trap_cmd.tval = trap_req.tval;
			redirect.pc = exc_to_s ? stvec : mtvec;
		end
		else if (ret_req.mret)
		begin
			trap_cmd.do_mret = 1'b1;
			redirect.pc = mepc;
		end
		else if (ret_req.sret)
		begin
			trap_cmd.do_sret = 1'b1;
			redirect.pc = sepc;
		end
		else if (irq_entry)
		begin
			trap_cmd.take = 1'b1;
			trap_cmd.to_s = irq_to_s;
			trap_cmd.is_irq = 1'b1;
			trap_cmd.code = irq_code;
			trap_cmd.epc = trap_req.pc; // resume point of the interrupted stream
			redirect.pc = irq_to_s ? stvec : mtvec;
		end
		redirect.valid = trap_cmd.take || trap_cmd.do_mret || trap_cmd.do_sret;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			irq_taken <= 1'b0;
		else
			irq_taken <= irq_entry;
	end

endmodule

// File: src/csr_regfile.sv
`include "csr_defines.svh"

module csr_regfile
(
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_addr_t csr_raddr,
	input csr_pkg::csr_access_t csr_wr,
	input priv_pkg::trap_cmd_t trap_cmd,
	input logic mtip,
	input logic stip,
	input logic m_ext_irq,
	input logic s_ext_irq,
	input csr_pkg::timer_view_t timer_view,
	output csr_pkg::csr_data_t csr_rdata,
	output csr_pkg::status_t status,
	output logic [3:0] mie_bits, // meie, mtie, seie, stie
	output logic [15:0] medeleg,
	output logic [15:0] mideleg,
	output csr_pkg::csr_data_t mtvec,
	output csr_pkg::csr_data_t stvec,
	output csr_pkg::csr_data_t mepc,
	output csr_pkg::csr_data_t sepc
);
	logic [`XLEN-1:2] mtvec_q;
	logic [`XLEN-1:2] stvec_q;
	logic [`XLEN-1:2] mepc_q;
	logic [`XLEN-1:2] sepc_q;
	csr_pkg::csr_data_t mscratch;
	csr_pkg::csr_data_t sscratch;
	csr_pkg::csr_data_t mtval;
	csr_pkg::csr_data_t stval;
	logic mcause_irq;
	priv_pkg::cause_code_t mcause_code;
	logic scause_irq;
	priv_pkg::cause_code_t scause_code;
	csr_pkg::csr_data_t wdata;
	logic wr_en;
	csr_pkg::csr_data_t mstatus_w;
	csr_pkg::csr_data_t mie_w;
	csr_pkg::csr_data_t mip_w;

	assign wdata = csr_wr.wdata;
	// traps and returns win over a write in the same cycle
	assign wr_en = csr_wr.we && !(trap_cmd.take || trap_cmd.do_mret || trap_cmd.do_sret);

	assign mtvec = {mtvec_q, 2'b00}; // direct mode only
	assign stvec = {stvec_q, 2'b00};
	assign mepc = {mepc_q, 2'b00};
	assign sepc = {sepc_q, 2'b00};

	assign mstatus_w = {13'b0, status.sum, 5'b0, status.mpp, 2'b0, status.spp, status.mpie,
		1'b0, status.spie, 1'b0, status.mie, 1'b0, status.sie, 1'b0};
	assign mie_w = {20'b0, mie_bits[3], 1'b0, mie_bits[1], 1'b0, mie_bits[2], 1'b0,
		mie_bits[0], 5'b0};
	assign mip_w = {20'b0, m_ext_irq, 1'b0, s_ext_irq, 1'b0, mtip, 1'b0, stip, 5'b0};

	// mode, status, enables and delegation
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			status <= '0;
			status.mode <= priv_pkg::M;
			mie_bits <= '0;
			medeleg <= '0;
			mideleg <= '0;
		end
		else if (trap_cmd.take && trap_cmd.to_s)
		begin
			status.spie <= status.sie;
			status.sie <= 1'b0;
			status.spp <= (status.mode == priv_pkg::S);
			status.mode <= priv_pkg::S;
		end
		else if (trap_cmd.take)
		begin
			status.mpie <= status.mie;
			status.mie <= 1'b0;
			status.mpp <= status.mode;
			status.mode <= priv_pkg::M;
		end
		else if (trap_cmd.do_mret)
		begin
			status.mode <= status.mpp;
			status.mie <= status.mpie;
			status.mpie <= 1'b1;
			status.mpp <= priv_pkg::U;
		end
		else if (trap_cmd.do_sret)
		begin
			status.mode <= status.spp ? priv_pkg::S : priv_pkg::U;
			status.sie <= status.spie;
			status.spie <= 1'b1;
			status.spp <= 1'b0;
		end
		else if (wr_en)
		begin
			case (csr_wr.addr)
			`CSR_MSTATUS:
			begin
				status.sie <= wdata[1];
				status.mie <= wdata[3];
				status.spie <= wdata[5];
				status.mpie <= wdata[7];
				status.spp <= wdata[8];
				// reserved encoding 2 falls back to U
				status.mpp <= (wdata[12:11] == 2'b10) ? priv_pkg::U
					: priv_pkg::mode_t'(wdata[12:11]);
				status.sum <= wdata[18];
			end
			`CSR_SSTATUS:
			begin
				status.sie <= wdata[1];
				status.spie <= wdata[5];
				status.spp <= wdata[8];
				status.sum <= wdata[18];
			end
			`CSR_MIE: mie_bits <= {wdata[11], wdata[7], wdata[9], wdata[5]};
			`CSR_SIE: mie_bits[1:0] <= {wdata[9], wdata[5]};
			`CSR_MEDELEG: medeleg <= wdata[15:0];
			`CSR_MIDELEG: mideleg <= wdata[15:0];
			default: ;
			endcase
		end
	end

	// trap payload and software registers
	always_ff @(posedge clk)
	begin
		if (trap_cmd.take && trap_cmd.to_s)
		begin
			sepc_q <= trap_cmd.epc[`XLEN-1:2];
			scause_irq <= trap_cmd.is_irq;
			scause_code <= trap_cmd.code;
			stval <= trap_cmd.is_irq ? '0 : trap_cmd.tval;
		end
		else if (trap_cmd.take)
		begin
			mepc_q <= trap_cmd.epc[`XLEN-1:2];
			mcause_irq <= trap_cmd.is_irq;
			mcause_code <= trap_cmd.code;
			mtval <= trap_cmd.is_irq ? '0 : trap_cmd.tval;
		end
		else if (wr_en)
		begin
			case (csr_wr.addr)
			`CSR_MTVEC: mtvec_q <= wdata[`XLEN-1:2];
			`CSR_STVEC: stvec_q <= wdata[`XLEN-1:2];
			`CSR_MEPC: mepc_q <= wdata[`XLEN-1:2];
			`CSR_SEPC: sepc_q <= wdata[`XLEN-1:2];
			`CSR_MSCRATCH: mscratch <= wdata;
			`CSR_SSCRATCH: sscratch <= wdata;
			`CSR_MTVAL: mtval <= wdata;
			`CSR_STVAL: stval <= wdata;
			`CSR_MCAUSE:
			begin
				mcause_irq <= wdata[`XLEN-1];
				mcause_code <= wdata[4:0];
			end
			`CSR_SCAUSE:
			begin
				scause_irq <= wdata[`XLEN-1];
				scause_code <= wdata[4:0];
			end
			default: ;
			endcase
		end
	end

	always_comb
	begin
		case (csr_raddr)
		`CSR_MISA: csr_rdata = `MISA_VALUE;
		`CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: csr_rdata = '0;
		`CSR_MSTATUS: csr_rdata = mstatus_w;
		`CSR_SSTATUS: csr_rdata = mstatus_w & 32'h0004_0122; // sie, spie, spp, sum
		`CSR_MIE: csr_rdata = mie_w;
		`CSR_SIE: csr_rdata = mie_w & 32'h0000_0220;
		`CSR_MIP: csr_rdata = mip_w;
		`CSR_SIP: csr_rdata = mip_w & 32'h0000_0220;
		`CSR_MTVEC: csr_rdata = mtvec;
		`CSR_STVEC: csr_rdata = stvec;
		`CSR_MEPC: csr_rdata = mepc;
		`CSR_SEPC: csr_rdata = sepc;
		`CSR_MCAUSE: csr_rdata = {mcause_irq, {(`XLEN-6){1'b0}}, mcause_code};
		`CSR_SCAUSE: csr_rdata = {scause_irq, {(`XLEN-6){1'b0}}, scause_code};
		`CSR_MTVAL: csr_rdata = mtval;
		`CSR_STVAL: csr_rdata = stval;
		`CSR_MSCRATCH: csr_rdata = mscratch;
		`CSR_SSCRATCH: csr_rdata = sscratch;
		`CSR_MEDELEG: csr_rdata = {16'b0, medeleg};
		`CSR_MIDELEG: csr_rdata = {16'b0, mideleg};
		`CSR_MCYCLE: csr_rdata = timer_view.cycle;
		`CSR_MTIMECMP: csr_rdata = timer_view.mtimecmp;
		`CSR_STIMECMP: csr_rdata = timer_view.stimecmp;
		default: csr_rdata = '0; // unimplemented
		endcase
	end

endmodule

// File: src/csr_timer.sv
`include "csr_defines.svh"

module csr_timer
(
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_access_t csr_wr,
	output csr_pkg::timer_view_t timer_view,
	output logic mtip,
	output logic stip
);
	csr_pkg::csr_data_t cycle;
	csr_pkg::csr_data_t mtimecmp;
	csr_pkg::csr_data_t stimecmp;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			cycle <= '0;
			mtimecmp <= '1; // far future, nothing pending
			stimecmp <= '1;
			mtip <= 1'b0;
			stip <= 1'b0;
		end
		else
		begin
			cycle <= cycle + 1'b1;
			mtip <= (cycle >= mtimecmp); // held until the compare moves up
			stip <= (cycle >= stimecmp);
			if (csr_wr.we && csr_wr.addr == `CSR_MTIMECMP)
				mtimecmp <= csr_wr.wdata;
			if (csr_wr.we && csr_wr.addr == `CSR_STIMECMP)
				stimecmp <= csr_wr.wdata;
		end
	end

	assign timer_view = '{cycle: cycle, mtimecmp: mtimecmp, stimecmp: stimecmp};

endmodule

// File: src/irq_arbiter.sv
module irq_arbiter
(
	input csr_pkg::status_t status,
	input logic [3:0] mie_bits, // meie, mtie, seie, stie
	input logic [15:0] mideleg,
	input logic mtip,
	input logic stip,
	input logic m_ext_irq,
	input logic s_ext_irq,
	output logic irq_valid,
	output priv_pkg::cause_code_t irq_code
);
	logic m_ok;
	logic s_ok;
	logic [3:0] pend; // highest priority at the top: MEI, MTI, SEI, STI
	logic [3:0] deleg;
	logic [3:0] ok;

	// M level interrupts are masked only inside M with MIE low
	assign m_ok = (status.mode != priv_pkg::M) || status.mie;
	assign s_ok = (status.mode == priv_pkg::U) || (status.mode == priv_pkg::S && status.sie);

	assign pend = {m_ext_irq, mtip, s_ext_irq, stip} & mie_bits;
	assign deleg = {mideleg[11], mideleg[7], mideleg[9], mideleg[5]};

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			ok[i] = pend[i] && (deleg[i] ? s_ok : m_ok);
		irq_valid = |ok;
		if (ok[3])
			irq_code = 5'd11;
		else if (ok[2])
			irq_code = 5'd7;
		else if (ok[1])
			irq_code = 5'd9;
		else
			irq_code = 5'd5; // only meaningful with irq_valid
	end

endmodule

// File: src/trap_unit_top.sv
module trap_unit_top
(
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_addr_t csr_raddr,
	input csr_pkg::csr_access_t csr_wr,
	input priv_pkg::trap_req_t trap_req,
	input priv_pkg::ret_req_t ret_req,
	input logic stall,
	input logic m_ext_irq,
	input logic s_ext_irq,
	output csr_pkg::csr_data_t csr_rdata,
	output priv_pkg::redirect_t redirect,
	output priv_pkg::mode_t mode,
	output logic irq_taken
);
	csr_pkg::status_t status;
	priv_pkg::trap_cmd_t trap_cmd;
	csr_pkg::timer_view_t timer_view;
	logic [3:0] mie_bits;
	logic [15:0] medeleg;
	logic [15:0] mideleg;
	csr_pkg::csr_data_t mtvec;
	csr_pkg::csr_data_t stvec;
	csr_pkg::csr_data_t mepc;
	csr_pkg::csr_data_t sepc;
	logic mtip;
	logic stip;
	logic irq_valid;
	priv_pkg::cause_code_t irq_code;

	assign mode = status.mode;

	trap_ctrl i_trap_ctrl (.clk(clk), .nrst(nrst), .trap_req(trap_req), .ret_req(ret_req),
		.stall(stall), .irq_valid(irq_valid), .irq_code(irq_code), .status(status),
		.medeleg(medeleg), .mideleg(mideleg), .mtvec(mtvec), .stvec(stvec), .mepc(mepc),
		.sepc(sepc), .trap_cmd(trap_cmd), .redirect(redirect), .irq_taken(irq_taken));

	csr_regfile i_csr_regfile (.clk(clk), .nrst(nrst), .csr_raddr(csr_raddr),
		.csr_wr(csr_wr), .trap_cmd(trap_cmd), .mtip(mtip), .stip(stip),
		.m_ext_irq(m_ext_irq), .s_ext_irq(s_ext_irq), .timer_view(timer_view),
		.csr_rdata(csr_rdata), .status(status), .mie_bits(mie_bits), .medeleg(medeleg),
		.mideleg(mideleg), .mtvec(mtvec), .stvec(stvec), .mepc(mepc), .sepc(sepc));

	csr_timer i_csr_timer (.clk(clk), .nrst(nrst), .csr_wr(csr_wr),
		.timer_view(timer_view), .mtip(mtip), .stip(stip));

	irq_arbiter i_irq_arbiter (.status(status), .mie_bits(mie_bits), .mideleg(mideleg),
		.mtip(mtip), .stip(stip), .m_ext_irq(m_ext_irq), .s_ext_irq(s_ext_irq),
		.irq_valid(irq_valid), .irq_code(irq_code));

endmodule

// File: dv/tb_trap_unit.sv
`include "csr_defines.svh"

module tb_trap_unit;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 2000; // far above the length of all tests

	logic clk;
	logic nrst;
	csr_pkg::csr_addr_t csr_raddr;
	csr_pkg::csr_access_t csr_wr;
	priv_pkg::trap_req_t trap_req;
	priv_pkg::ret_req_t ret_req;
	logic stall;
	logic m_ext_irq;
	logic s_ext_irq;
	csr_pkg::csr_data_t csr_rdata;
	priv_pkg::redirect_t redirect;
	priv_pkg::mode_t mode;
	logic irq_taken;
	int cycles;
	int seed_ret;

	trap_unit_top i_trap_unit_top (.clk(clk), .nrst(nrst), .csr_raddr(csr_raddr),
		.csr_wr(csr_wr), .trap_req(trap_req), .ret_req(ret_req), .stall(stall),
		.m_ext_irq(m_ext_irq), .s_ext_irq(s_ext_irq), .csr_rdata(csr_rdata),
		.redirect(redirect), .mode(mode), .irq_taken(irq_taken));

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	task automatic check_data(input string test, input csr_pkg::csr_data_t exp,
		input csr_pkg::csr_data_t act);
		if (act !== exp)
		begin
			$display("ERROR %s: expected %h, actual %h", test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_mode(input string test, input priv_pkg::mode_t exp,
		input priv_pkg::mode_t act);
		if (act !== exp)
		begin
			$display("ERROR %s: expected mode %0d, actual mode %0d", test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_redirect(input string test, input priv_pkg::redirect_t exp,
		input priv_pkg::redirect_t act);
		if (act !== exp)
		begin
			$display("ERROR %s: expected valid %b pc %h, actual valid %b pc %h", test,
				exp.valid, exp.pc, act.valid, act.pc);
			stop_run();
		end
	endtask

	function automatic priv_pkg::redirect_t jump_to(input csr_pkg::csr_data_t pc);
		priv_pkg::redirect_t r;
		r.valid = 1'b1;
		r.pc = pc;
		return r;
	endfunction

	task automatic csr_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
		@(posedge clk);
		csr_wr <= '{we: 1'b1, addr: addr, wdata: data};
		@(posedge clk);
		csr_wr.we <= 1'b0; // committed on this edge
	endtask

	task automatic csr_read(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
		@(posedge clk);
		csr_raddr <= addr;
		@(negedge clk);
		data = csr_rdata;
	endtask

	task automatic raise_exception(input priv_pkg::cause_code_t code,
		input csr_pkg::csr_data_t pc, input csr_pkg::csr_data_t tval,
		output priv_pkg::redirect_t seen);
		@(posedge clk);
		trap_req <= '{valid: 1'b1, code: code, pc: pc, tval: tval};
		@(negedge clk);
		seen = redirect; // same-cycle redirect
		@(posedge clk);
		trap_req.valid <= 1'b0;
	endtask

	task automatic do_ret(input logic is_mret, output priv_pkg::redirect_t seen);
		@(posedge clk);
		ret_req <= '{mret: is_mret, sret: !is_mret};
		@(negedge clk);
		seen = redirect;
		@(posedge clk);
		ret_req <= '0;
	endtask

	// keeps the entry redirect and returns on the irq_taken pulse
	task automatic wait_irq(input int limit, input string test,
		output priv_pkg::redirect_t seen);
		int n;
		n = 0;
		seen = '0;
		@(negedge clk);
		while (!irq_taken)
		begin
			if (redirect.valid)
				seen = redirect;
			n++;
			if (n > limit)
			begin
				$display("%s: no interrupt taken within %0d cycles", test, limit);
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic expect_no_irq(input int n, input string test);
		repeat (n)
		begin
			@(negedge clk);
			if (irq_taken || redirect.valid)
			begin
				$display("%s: interrupt taken while it should be held back", test);
				stop_run();
			end
		end
	endtask

	task automatic test_reset_csr();
		csr_pkg::csr_data_t d;
		csr_pkg::csr_data_t rd;
		@(negedge clk);
		check_mode("reset_mode", priv_pkg::M, mode);
		csr_read(`CSR_MISA, rd);
		check_data("reset_misa", `MISA_VALUE, rd);
		csr_read(`CSR_MCYCLE, rd);
		if (rd == 0 || $isunknown(rd))
		begin
			$display("mcycle did not count after reset");
			stop_run();
		end
		repeat (4)
		begin
			d = $urandom;
			csr_write(`CSR_MSCRATCH, d);
			csr_read(`CSR_MSCRATCH, rd);
			check_data("mscratch_rw", d, rd);
			d = $urandom;
			csr_write(`CSR_SSCRATCH, d);
			csr_read(`CSR_SSCRATCH, rd);
			check_data("sscratch_rw", d, rd);
		end
		d = $urandom;
		csr_write(`CSR_MTVEC, d);
		csr_read(`CSR_MTVEC, rd);
		check_data("mtvec_align", d & ~32'h3, rd);
		d = $urandom;
		csr_write(`CSR_MEPC, d);
		csr_read(`CSR_MEPC, rd);
		check_data("mepc_align", d & ~32'h3, rd);
		csr_read(12'h7FF, rd);
		check_data("unimplemented", 32'h0, rd);
	endtask

	task automatic test_machine_trap();
		csr_pkg::csr_data_t pc;
		csr_pkg::csr_data_t tval;
		csr_pkg::csr_data_t rd;
		priv_pkg::redirect_t seen;
		pc = $urandom & ~32'h3;
		tval = $urandom;
		csr_write(`CSR_MTVEC, 32'h8000_0100);
		csr_write(`CSR_MSTATUS, 32'h0000_0008); // MIE only
		raise_exception(5'd2, pc, tval, seen);
		check_redirect("m_trap_redirect", jump_to(32'h8000_0100), seen);
		csr_read(`CSR_MEPC, rd);
		check_data("m_trap_mepc", pc, rd);
		csr_read(`CSR_MCAUSE, rd);
		check_data("m_trap_mcause", 32'd2, rd);
		csr_read(`CSR_MTVAL, rd);
		check_data("m_trap_mtval", tval, rd);
		csr_read(`CSR_MSTATUS, rd);
		check_data("m_trap_mstatus", 32'h0000_1880, rd); // MPP=M, MPIE=1, MIE=0
		pc = $urandom & ~32'h3;
		csr_write(`CSR_MSTATUS, 32'h0000_0080); // MPP=U, MPIE=1
		csr_write(`CSR_MEPC, pc);
		do_ret(1'b1, seen);
		check_redirect("mret_redirect", jump_to(pc), seen);
		@(negedge clk);
		check_mode("mret_mode", priv_pkg::U, mode);
	endtask

	task automatic test_delegation();
		csr_pkg::csr_data_t pc;
		csr_pkg::csr_data_t tval;
		csr_pkg::csr_data_t rd;
		priv_pkg::redirect_t seen;
		pc = $urandom & ~32'h3;
		tval = $urandom;
		csr_write(`CSR_STVEC, 32'h8000_0200);
		csr_write(`CSR_MEDELEG, 32'h0000_0100); // ecall from U
		csr_write(`CSR_SSTATUS, 32'h0000_0002);
		raise_exception(5'd8, pc, tval, seen);
		check_redirect("deleg_redirect", jump_to(32'h8000_0200), seen);
		@(negedge clk);
		check_mode("deleg_mode", priv_pkg::S, mode);
		csr_read(`CSR_SEPC, rd);
		check_data("deleg_sepc", pc, rd);
		csr_read(`CSR_SCAUSE, rd);
		check_data("deleg_scause", 32'd8, rd);
		csr_read(`CSR_STVAL, rd);
		check_data("deleg_stval", tval, rd);
		csr_read(`CSR_SSTATUS, rd);
		check_data("deleg_sstatus", 32'h0000_0020, rd); // SPP=U, SPIE=1, SIE=0
		do_ret(1'b0, seen);
		check_redirect("sret_redirect", jump_to(pc), seen);
		@(negedge clk);
		check_mode("sret_mode", priv_pkg::U, mode);
		// same code without delegation lands in M
		csr_write(`CSR_MEDELEG, 32'h0);
		pc = $urandom & ~32'h3;
		raise_exception(5'd8, pc, tval, seen);
		check_redirect("nodeleg_redirect", jump_to(32'h8000_0100), seen);
		@(negedge clk);
		check_mode("nodeleg_mode", priv_pkg::M, mode);
		csr_read(`CSR_MEPC, rd);
		check_data("nodeleg_mepc", pc, rd);
	endtask

	task automatic test_timer_irq();
		csr_pkg::csr_data_t now;
		csr_pkg::csr_data_t rd;
		priv_pkg::redirect_t seen;
		csr_write(`CSR_MSTATUS, 32'h0000_0008);
		csr_write(`CSR_MIE, 32'h0000_0080); // MTIE
		csr_read(`CSR_MCYCLE, now);
		csr_write(`CSR_MTIMECMP, now + 32'd20);
		wait_irq(40, "timer_irq", seen);
		check_redirect("timer_redirect", jump_to(32'h8000_0100), seen);
		csr_read(`CSR_MCAUSE, rd);
		check_data("timer_mcause", 32'h8000_0007, rd);
		// mtip stays high so only the stall holds back the second entry
		@(posedge clk);
		stall <= 1'b1;
		csr_write(`CSR_MCAUSE, 32'h0);
		csr_write(`CSR_MSTATUS, 32'h0000_0008);
		expect_no_irq(12, "timer_stall");
		@(posedge clk);
		stall <= 1'b0;
		wait_irq(10, "timer_unstall", seen);
		check_redirect("unstall_redirect", jump_to(32'h8000_0100), seen);
		csr_read(`CSR_MCAUSE, rd);
		check_data("unstall_mcause", 32'h8000_0007, rd);
		csr_write(`CSR_MTIMECMP, 32'hFFFF_FFFF);
	endtask

	task automatic test_sext_irq();
		csr_pkg::csr_data_t pc;
		csr_pkg::csr_data_t rd;
		priv_pkg::redirect_t seen;
		pc = $urandom & ~32'h3;
		csr_write(`CSR_MIE, 32'h0000_0200); // SEIE
		csr_write(`CSR_MIDELEG, 32'h0000_0200);
		csr_write(`CSR_MEPC, pc);
		@(posedge clk);
		s_ext_irq <= 1'b1;
		csr_write(`CSR_MSTATUS, 32'h0000_0008); // MIE=1, MPP=U
		expect_no_irq(10, "sext_in_m");
		do_ret(1'b1, seen);
		check_redirect("sext_mret", jump_to(pc), seen);
		wait_irq(10, "sext_irq", seen);
		check_redirect("sext_redirect", jump_to(32'h8000_0200), seen);
		@(negedge clk);
		check_mode("sext_mode", priv_pkg::S, mode);
		csr_read(`CSR_SCAUSE, rd);
		check_data("sext_scause", 32'h8000_0009, rd);
		@(posedge clk);
		s_ext_irq <= 1'b0;
	endtask

	initial
	begin
		seed_ret = $urandom(24);
		cycles = 0;
		nrst = 1'b0;
		csr_raddr = '0;
		csr_wr = '0;
		trap_req = '0;
		ret_req = '0;
		stall = 1'b0;
		m_ext_irq = 1'b0;
		s_ext_irq = 1'b0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		test_reset_csr();
		test_machine_trap();
		test_delegation();
		test_timer_irq();
		test_sext_irq();
		repeat (2) @(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: files.f
+incdir+include
src/priv_pkg.sv
src/csr_pkg.sv
src/trap_ctrl.sv
src/csr_regfile.sv
src/csr_timer.sv
src/irq_arbiter.sv
src/trap_unit_top.sv
dv/tb_trap_unit.sv

// File: Bender.yml
package:
  name: trap_unit

export_include_dirs:
  - include

sources:
  - src/priv_pkg.sv
  - src/csr_pkg.sv
  - src/trap_ctrl.sv
  - src/csr_regfile.sv
  - src/csr_timer.sv
  - src/irq_arbiter.sv
  - src/trap_unit_top.sv
  - target: test
    files:
      - dv/tb_trap_unit.sv
